// ==== files.f ====
+incdir+source
source/i2c_bus_pkg.sv
source/i2c_seq_pkg.sv
source/i2c_bit_if.sv
source/i2c_cmd_if.sv
source/i2c_cmd_regs.sv
source/i2c_bit_engine.sv
source/i2c_byte_sequencer.sv
source/i2c_eeprom_master.sv
sim/i2c_eeprom_model.sv
sim/i2c_eeprom_assertions.sv
sim/tb_i2c_eeprom_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module tb_i2c_eeprom_master -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1

// ==== sim/i2c_eeprom_assertions.sv ====
`timescale 1ns/1ps

module i2c_eeprom_assertions (
	input logic clk,
	input logic reset_n,
	input logic busy,
	input logic done,
	input logic nack,
	input logic scl,
	input logic sda_pull,
	input i2c_bus_pkg::bus_op_e op
);
	import i2c_bus_pkg::*;

	a_busy_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !busy)
		else $error("busy is high right after reset");

	a_pulse_needs_busy: assert property (@(posedge clk) disable iff (!reset_n)
		(done || nack) |-> $past(busy))
		else $error("done or nack pulsed without a transfer in progress");

	// a data line edge under a high clock is a start or stop condition
	a_sda_stable: assert property (@(posedge clk) disable iff (!reset_n)
		(scl && $past(scl) && sda_pull != $past(sda_pull))
		|-> (op == op_start || op == op_restart || op == op_stop))
		else $error("SDA moved while SCL was high during a data bit");

endmodule

bind i2c_eeprom_master i2c_eeprom_assertions u_assert (
	.clk(clk), .reset_n(reset_n), .busy(busy), .done(done), .nack(nack),
	.scl(scl), .sda_pull(sda_pull), .op(bit_ch.op)
);

// ==== sim/i2c_eeprom_model.sv ====
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_eeprom_model (
	input logic clk,
	input logic scl,
	input logic sda,
	output logic pull
);
	logic [7:0] mem [0:4095];
	logic [7:0] sh;
	logic [7:0] addr_hi = 8'h00;
	logic [11:0] ptr = 12'h000;
	logic prev_scl = 1'b1;
	logic prev_sda = 1'b1;
	logic drive_low = 1'b0;
	logic ack;
	int cnt = 0;
	int phase = 0; // 0 idle, 1 device, 2 addr high, 3 addr low, 4 write data, 5 send data
	int next_phase = 0;

	assign pull = drive_low;

	initial begin
		for (int a = 0; a < 4096; a++)
			mem[a[11:0]] = a[7:0] ^ a[15:8];
	end

	// bus edges are seen one clock late, always while SCL is stable
	always @(posedge clk) begin
		if (prev_scl && scl && prev_sda && !sda) begin
			phase = 1; // start or repeated start
			cnt = 0;
			drive_low <= 1'b0;
		end else if (prev_scl && scl && !prev_sda && sda) begin
			phase = 0;
			drive_low <= 1'b0;
		end else if (!prev_scl && scl) begin
			if (cnt < 8 && phase != 5)
				sh = {sh[6:0], sda};
			cnt = cnt + 1;
		end else if (prev_scl && !scl && phase != 0) begin
			if (cnt == 8 && phase == 5) begin
				drive_low <= 1'b0; // the master acknowledges this one
			end else if (cnt == 8) begin
				ack = 1'b1;
				case (phase)
					1: begin
						ack = (sh[7:1] == `I2C_DEV_ADDR);
						next_phase = sh[0] ? 5 : 2;
						sh = mem[ptr];
					end
					2: begin
						ack = (sh < 8'h10); // only 4 KiB behind this device
						addr_hi = sh;
						next_phase = 3;
					end
					3: begin
						ptr = {addr_hi[3:0], sh};
						next_phase = 4;
					end
					default: begin
						mem[ptr] = sh;
						next_phase = 0;
					end
				endcase
				if (!ack)
					next_phase = 0;
				drive_low <= ack;
			end else if (cnt == 9) begin
				cnt = 0;
				phase = next_phase;
				next_phase = 0;
				drive_low <= (phase == 5) && !sh[7];
				sh = {sh[6:0], 1'b0};
			end else if (phase == 5) begin
				drive_low <= !sh[7];
				sh = {sh[6:0], 1'b0};
			end
		end
		prev_scl = scl;
		prev_sda = sda;
	end

endmodule

module i2c_eeprom_checker (
	input logic clk,
	input logic busy,
	input logic done,
	input logic nack,
	input logic scl,
	input logic sda_pull,
	input logic [7:0] rd_data,
	input int row,
	input logic exp_read,
	input logic exp_nack,
	input logic [7:0] exp_rd,
	input logic row_end,
	input logic reset_check,
	input logic report,
	output int passed,
	output int failed
);
	int n_pass = 0;
	int n_fail = 0;
	int dones = 0;
	logic bad = 1'b0;

	assign passed = n_pass;
	assign failed = n_fail;

	task automatic compare_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			$display("mismatch at %0t: %s expected 0x%02h, actual 0x%02h", $time, name, exp, act);
			bad = 1'b1;
		end
	endtask

	task automatic close_test(input string what);
		if (bad)
			n_fail = n_fail + 1;
		else
			n_pass = n_pass + 1;
		$display("%s %s", what, bad ? "failed" : "passed");
		bad = 1'b0;
		dones = 0;
	endtask

	always @(posedge clk) begin
		if (reset_check) begin
			compare_value("busy", 8'h00, {7'd0, busy});
			compare_value("done", 8'h00, {7'd0, done});
			compare_value("nack", 8'h00, {7'd0, nack});
			compare_value("scl", 8'h01, {7'd0, scl});
			compare_value("sda_pull", 8'h00, {7'd0, sda_pull});
			close_test("reset state");
		end
		if (done) begin
			dones = dones + 1;
			compare_value("nack", {7'd0, exp_nack}, {7'd0, nack});
			if (exp_read && !exp_nack)
				compare_value("rd_data", exp_rd, rd_data);
		end
		if (row_end) begin
			if (dones != 1) begin
				$display("test %0d saw %0d done pulses instead of one", row, dones);
				bad = 1'b1;
			end
			compare_value("scl", 8'h01, {7'd0, scl}); // bus must be released again
			compare_value("sda_pull", 8'h00, {7'd0, sda_pull});
			compare_value("busy", 8'h00, {7'd0, busy});
			close_test($sformatf("test %0d", row));
		end
		if (report)
			$display("%0d tests passed, %0d tests failed", n_pass, n_fail);
	end

endmodule

// ==== sim/tb_i2c_eeprom_master.sv ====
`timescale 1ns/1ps
`include "i2c_consts.svh"

module tb_i2c_eeprom_master;
	localparam int ROWS = 12;
	localparam int WAIT_CLKS = 80 * `I2C_BIT_CLKS;

	logic clk = 1'b0;
	logic reset_n = 1'b0;
	logic wr_req = 1'b0;
	logic rd_req = 1'b0;
	logic [`I2C_REG_AW-1:0] reg_addr = '0;
	logic [7:0] wr_data = 8'h00;
	logic sda_in;
	logic [7:0] rd_data;
	logic busy;
	logic done;
	logic nack;
	logic scl;
	logic sda_pull;
	logic model_pull;

	int row = 0;
	logic exp_read = 1'b0;
	logic exp_nack = 1'b0;
	logic [7:0] exp_rd = 8'h00;
	logic row_end = 1'b0;
	logic reset_check = 1'b0;
	logic report = 1'b0;
	int passed;
	int failed;
	logic hung = 1'b0;
	integer seed;
	logic [7:0] r1;
	logic [7:0] r2;

	// each test row holds the read flag, address, data, second strobe flag, nack and byte expected
	logic t_read [ROWS];
	logic [`I2C_REG_AW-1:0] t_addr [ROWS];
	logic [7:0] t_data [ROWS];
	logic t_twice [ROWS];
	logic t_nack [ROWS];
	logic [7:0] t_exp [ROWS];

	always #4 clk = ~clk;

	assign sda_in = !(sda_pull || model_pull); // open-drain bus with a pull-up

	i2c_eeprom_master u_dut (
		.clk(clk), .reset_n(reset_n), .wr_req(wr_req), .rd_req(rd_req),
		.reg_addr(reg_addr), .wr_data(wr_data), .sda_in(sda_in), .rd_data(rd_data),
		.busy(busy), .done(done), .nack(nack), .scl(scl), .sda_pull(sda_pull)
	);

	i2c_eeprom_model u_model (.clk(clk), .scl(scl), .sda(sda_in), .pull(model_pull));

	i2c_eeprom_checker u_chk (
		.clk(clk), .busy(busy), .done(done), .nack(nack), .scl(scl), .sda_pull(sda_pull),
		.rd_data(rd_data), .row(row), .exp_read(exp_read), .exp_nack(exp_nack),
		.exp_rd(exp_rd), .row_end(row_end), .reset_check(reset_check), .report(report),
		.passed(passed), .failed(failed)
	);

	task automatic add_row(input int idx, input logic rd, input logic [`I2C_REG_AW-1:0] addr,
		input logic [7:0] data, input logic twice, input logic enack, input logic [7:0] erd);
		t_read[idx] = rd;
		t_addr[idx] = addr;
		t_data[idx] = data;
		t_twice[idx] = twice;
		t_nack[idx] = enack;
		t_exp[idx] = erd;
	endtask

	task automatic wait_busy();
		int n;
		n = 0;
		while (!busy && n < WAIT_CLKS) begin
			@(posedge clk);
			n++;
		end
		if (!busy) begin
			$display("test %0d: busy never rose after the strobe", row);
			hung = 1'b1;
		end
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!done && n < WAIT_CLKS) begin
			@(posedge clk);
			n++;
		end
		if (!done) begin
			$display("test %0d: the transfer never finished", row);
			hung = 1'b1;
		end
	endtask

	initial begin
		seed = 32'h17cceff1;
		r1 = 8'($random(seed));
		r2 = 8'($random(seed));
		add_row(0, 1'b0, 16'h0123, r1, 1'b0, 1'b0, 8'h00);
		add_row(1, 1'b1, 16'h0123, 8'h00, 1'b0, 1'b0, r1);
		add_row(2, 1'b0, 16'h0234, 8'ha5, 1'b0, 1'b0, 8'h00); // these two share the low byte
		add_row(3, 1'b0, 16'h0334, 8'h5a, 1'b0, 1'b0, 8'h00);
		add_row(4, 1'b1, 16'h0234, 8'h00, 1'b0, 1'b0, 8'ha5);
		add_row(5, 1'b1, 16'h0334, 8'h00, 1'b0, 1'b0, 8'h5a);
		add_row(6, 1'b1, 16'h0abc, 8'h00, 1'b0, 1'b0, 8'hbc ^ 8'h0a); // never written
		add_row(7, 1'b0, 16'h1200, 8'h77, 1'b0, 1'b1, 8'h00);
		add_row(8, 1'b1, 16'h8001, 8'h00, 1'b0, 1'b1, 8'h00);
		add_row(9, 1'b1, 16'h0123, 8'h00, 1'b0, 1'b0, r1);
		add_row(10, 1'b0, 16'h0456, r2, 1'b1, 1'b0, 8'h00);
		add_row(11, 1'b1, 16'h0456, 8'h00, 1'b0, 1'b0, r2);

		repeat (8) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
		reset_check <= 1'b1;
		@(posedge clk);
		reset_check <= 1'b0;

		for (int i = 0; i < ROWS; i++) begin
			@(posedge clk);
			row <= i;
			exp_read <= t_read[i];
			exp_nack <= t_nack[i];
			exp_rd <= t_exp[i];
			wr_req <= !t_read[i];
			rd_req <= t_read[i];
			reg_addr <= t_addr[i];
			wr_data <= t_data[i];
			@(posedge clk);
			wr_req <= 1'b0;
			rd_req <= 1'b0;
			if (t_twice[i]) begin
				wait_busy();
				if (hung)
					break;
				wr_req <= 1'b1; // this strobe lands while busy and must be dropped
				wr_data <= ~t_data[i];
				@(posedge clk);
				wr_req <= 1'b0;
			end
			wait_done();
			if (hung)
				break;
			repeat (4) @(posedge clk);
			row_end <= 1'b1;
			@(posedge clk);
			row_end <= 1'b0;
		end

		report <= 1'b1;
		@(posedge clk);
		report <= 1'b0;
		@(posedge clk);
		if (!hung && failed == 0 && passed == ROWS + 1)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== source/i2c_bit_engine.sv ====
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_bit_engine (
	input logic clk,
	input logic reset_n,
	i2c_bit_if.eng bus,
	input logic sda_in,
	output logic scl,
	output logic sda_pull
);
	import i2c_bus_pkg::*;

	localparam int unsigned CW = $clog2(`I2C_BIT_CLKS);
	localparam logic [CW-1:0] PH_Q1 = CW'(`I2C_BIT_CLKS / 4);
	localparam logic [CW-1:0] PH_Q2 = CW'(`I2C_BIT_CLKS / 2);
	localparam logic [CW-1:0] PH_Q3 = CW'(3 * `I2C_BIT_CLKS / 4);
	localparam logic [CW-1:0] PH_LAST = CW'(`I2C_BIT_CLKS - 1);

	logic active;
	logic [CW-1:0] cnt;
	bus_op_e op_q;
	logic tx_q;

	assign bus.op_done = active && (cnt == PH_LAST);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			active <= 1'b0;
			cnt <= '0;
		end else if (bus.op_valid) begin
			active <= 1'b1;
			cnt <= '0;
		end else if (active) begin
			cnt <= cnt + 1'b1;
			if (cnt == PH_LAST)
				active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.op_valid) begin
			op_q <= bus.op;
			tx_q <= bus.tx_bit;
		end
		if (active && cnt == PH_Q3)
			bus.rx_bit <= sda_in;
	end

	// SDA only moves at a quarter point, so its edges never meet an SCL edge
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			scl <= 1'b1;
			sda_pull <= 1'b0;
		end else if (active) begin
			case (op_q)
				op_start: begin
					if (cnt == PH_Q2) sda_pull <= 1'b1; // SDA falls under a high SCL
					if (cnt == PH_Q3) scl <= 1'b0;
				end
				op_restart: begin
					if (cnt == PH_Q1) sda_pull <= 1'b0;
					if (cnt == PH_Q2) scl <= 1'b1;
					if (cnt == PH_Q3) sda_pull <= 1'b1;
					if (cnt == PH_LAST) scl <= 1'b0;
				end
				op_stop: begin
					if (cnt == PH_Q1) sda_pull <= 1'b1;
					if (cnt == PH_Q2) scl <= 1'b1;
					if (cnt == PH_Q3) sda_pull <= 1'b0; // SCL stays high afterwards
				end
				default: begin
					if (cnt == '0) scl <= 1'b0;
					if (cnt == PH_Q1) sda_pull <= (op_q == op_write_bit) && !tx_q;
					if (cnt == PH_Q2) scl <= 1'b1;
					if (cnt == PH_LAST) scl <= 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== source/i2c_bit_if.sv ====
`timescale 1ns/1ps

interface i2c_bit_if;
	import i2c_bus_pkg::*;

	bus_op_e op;
	logic op_valid; // one cycle, only while no op is running
	logic tx_bit;
	logic op_done; // end of the bit period
	logic rx_bit; // SDA as seen at the SCL high midpoint

	modport seq (
		output op, op_valid, tx_bit,
		input op_done, rx_bit
	);

	modport eng (
		input op, op_valid, tx_bit,
		output op_done, rx_bit
	);

endinterface

// ==== source/i2c_bus_pkg.sv ====
package i2c_bus_pkg;

	// one bit period of bus activity, as run by the bit engine
	typedef enum logic [2:0] {
		op_start, // SDA falls with SCL high, then SCL falls
		op_restart,
		op_stop,
		op_write_bit,
		op_read_bit // also used to collect the acknowledge
	} bus_op_e;

	// start and restart both leave SCL low for the next bit
	// stop is the only op that ends with SCL high

endpackage

// ==== source/i2c_byte_sequencer.sv ====
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_byte_sequencer (
	input logic clk,
	input logic reset_n,
	i2c_cmd_if.seq cmd,
	i2c_bit_if.seq bus
);
	import i2c_bus_pkg::*;
	import i2c_seq_pkg::*;

	seq_state_e state;
	logic in_flight;
	logic [3:0] bit_cnt; // 0 to 7 are data bits, 8 is the acknowledge slot
	logic [7:0] shreg;
	logic [7:0] rd_shift;
	logic nack_flag;

	assign cmd.nacked = nack_flag;
	assign cmd.rd_byte = rd_shift;

	always_comb begin
		bus.tx_bit = (state == st_rd_data) ? 1'b1 : shreg[7]; // master NACK after the read byte
		case (state)
			st_start: bus.op = op_start;
			st_restart: bus.op = op_restart;
			st_stop: bus.op = op_stop;
			st_rd_data: bus.op = bit_cnt[3] ? op_write_bit : op_read_bit;
			default: bus.op = bit_cnt[3] ? op_read_bit : op_write_bit;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == st_rd_data && in_flight && bus.op_done && !bit_cnt[3])
			rd_shift <= {rd_shift[6:0], bus.rx_bit};
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= st_idle;
			in_flight <= 1'b0;
			bit_cnt <= 4'd0;
			nack_flag <= 1'b0;
			bus.op_valid <= 1'b0;
			cmd.finish <= 1'b0;
		end else begin
			bus.op_valid <= 1'b0;
			cmd.finish <= 1'b0;
			if (state == st_idle) begin
				if (cmd.start) begin
					state <= st_start;
					nack_flag <= 1'b0;
				end
			end else if (!in_flight) begin
				bus.op_valid <= 1'b1;
				in_flight <= 1'b1;
			end else if (bus.op_done) begin
				in_flight <= 1'b0;
				case (state)
					st_start: begin
						state <= st_dev_addr;
						shreg <= {`I2C_DEV_ADDR, 1'b0};
						bit_cnt <= 4'd0;
					end
					st_restart: begin
						state <= st_rd_dev_addr;
						shreg <= {`I2C_DEV_ADDR, 1'b1};
						bit_cnt <= 4'd0;
					end
					st_stop: begin
						state <= st_idle;
						cmd.finish <= 1'b1;
					end
					st_rd_data: begin
						if (!bit_cnt[3]) bit_cnt <= bit_cnt + 4'd1;
						else state <= st_stop;
					end
					default: begin
						if (!bit_cnt[3]) begin
							shreg <= {shreg[6:0], 1'b0};
							bit_cnt <= bit_cnt + 4'd1;
						end else if (bus.rx_bit) begin
							nack_flag <= 1'b1; // nobody answered, close the bus
							state <= st_stop;
						end else begin
							bit_cnt <= 4'd0;
							case (state)
								st_dev_addr: begin
									state <= st_addr_hi;
									shreg <= cmd.reg_addr[`I2C_REG_AW-1 -: 8];
								end
								st_addr_hi: begin
									state <= st_addr_lo;
									shreg <= cmd.reg_addr[7:0];
								end
								st_addr_lo: begin
									state <= (cmd.kind == cmd_write) ? st_wr_data : st_restart;
									shreg <= cmd.wr_data;
								end
								st_rd_dev_addr: state <= st_rd_data;
								default: state <= st_stop;
							endcase
						end
					end
				endcase
			end
		end
	end

endmodule

// ==== source/i2c_cmd_if.sv ====
`timescale 1ns/1ps
`include "i2c_consts.svh"

interface i2c_cmd_if;
	import i2c_seq_pkg::*;

	logic start;
	cmd_kind_e kind;
	logic [`I2C_REG_AW-1:0] reg_addr;
	logic [7:0] wr_data;

	// finish is a single pulse, nacked and rd_byte are held steady around it
	logic finish;
	logic nacked;
	logic [7:0] rd_byte;

	modport regs (
		output start, kind, reg_addr, wr_data,
		input finish, nacked, rd_byte
	);

	modport seq (
		input start, kind, reg_addr, wr_data,
		output finish, nacked, rd_byte
	);

endinterface

// ==== source/i2c_cmd_regs.sv ====
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_cmd_regs (
	input logic clk,
	input logic reset_n,
	input logic wr_req,
	input logic rd_req,
	input logic [`I2C_REG_AW-1:0] reg_addr,
	input logic [7:0] wr_data,
	output logic [7:0] rd_data,
	output logic busy,
	output logic done,
	output logic nack,
	i2c_cmd_if.regs cmd
);
	import i2c_seq_pkg::*;

	logic accept;

	assign accept = !busy && (wr_req || rd_req); // strobes while busy are dropped

	// request fields stay put until the next accepted strobe
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd.kind <= wr_req ? cmd_write : cmd_read; // write wins a tie
			cmd.reg_addr <= reg_addr;
			cmd.wr_data <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			nack <= 1'b0;
			cmd.start <= 1'b0;
			rd_data <= 8'h00;
		end else begin
			cmd.start <= 1'b0;
			done <= 1'b0;
			nack <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				cmd.start <= 1'b1;
			end else if (busy && cmd.finish) begin
				busy <= 1'b0;
				done <= 1'b1;
				nack <= cmd.nacked;
				if (cmd.kind == cmd_read && !cmd.nacked)
					rd_data <= cmd.rd_byte; // a failed read keeps the old value
			end
		end
	end

endmodule

// ==== source/i2c_consts.svh ====
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// system clocks per SCL bit, kept short for simulation
// must stay a multiple of 4 so the quarter points land on whole cycles
`define I2C_BIT_CLKS 40

// 7-bit EEPROM device address, the direction bit is appended later
`define I2C_DEV_ADDR 7'h50

`define I2C_REG_AW 16 // register address width, sent as two bytes

`endif

// ==== source/i2c_eeprom_master.sv ====
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_eeprom_master (
	input logic clk,
	input logic reset_n,
	input logic wr_req,
	input logic rd_req,
	input logic [`I2C_REG_AW-1:0] reg_addr,
	input logic [7:0] wr_data,
	input logic sda_in, // already resolved on the board side
	output logic [7:0] rd_data,
	output logic busy,
	output logic done,
	output logic nack,
	output logic scl,
	output logic sda_pull
);

	i2c_cmd_if cmd_ch ();
	i2c_bit_if bit_ch ();

	i2c_cmd_regs u_regs (
		.clk(clk), .reset_n(reset_n),
		.wr_req(wr_req), .rd_req(rd_req), .reg_addr(reg_addr), .wr_data(wr_data),
		.rd_data(rd_data), .busy(busy), .done(done), .nack(nack),
		.cmd(cmd_ch.regs)
	);

	i2c_byte_sequencer u_seq (.clk(clk), .reset_n(reset_n), .cmd(cmd_ch.seq), .bus(bit_ch.seq));

	i2c_bit_engine u_eng (
		.clk(clk), .reset_n(reset_n), .bus(bit_ch.eng),
		.sda_in(sda_in), .scl(scl), .sda_pull(sda_pull)
	);

endmodule

// ==== source/i2c_seq_pkg.sv ====
package i2c_seq_pkg;

	typedef enum logic [3:0] {
		st_idle,
		st_start,
		st_dev_addr,
		st_addr_hi, // address high byte goes first
		st_addr_lo,
		st_wr_data,
		st_restart,
		st_rd_dev_addr,
		st_rd_data,
		st_stop
	} seq_state_e;

	typedef enum logic {cmd_write, cmd_read} cmd_kind_e;

endpackage
